//--- drum_meter_pkg.sv
`default_nettype none

package drum_meter_pkg;

  typedef logic [7:0] midi_byte_t;
  typedef logic [6:0] midi_data_t;  // note number or velocity
  typedef logic [6:0] intensity_t;

  localparam int INSTRUMENT_COUNT = 3;

  // bass drum, snare, open hi-hat
  localparam midi_data_t INSTRUMENT_KEYS [INSTRUMENT_COUNT] = '{
    7'd36,
    7'd38,
    7'd46
  };

  // intensity lost per frame
  localparam intensity_t INSTRUMENT_DECAY [INSTRUMENT_COUNT] = '{
    7'd127,  // bass drum dies in one frame
    7'd16,
    7'd3     // hi-hat rings long
  };

  typedef enum logic [1:0] {
    IDLE,
    WAIT_KEY,
    WAIT_VELOCITY
  } parser_state_t;

endpackage

`default_nettype wire

//--- note_event_if.sv
`timescale 1ns/1ps
`default_nettype none

interface note_event_if
  import drum_meter_pkg::*;
();

  logic       req;
  logic       ack;
  midi_data_t note;
  midi_data_t velocity;  // held with note while req is up

  modport producer (
    output req, note, velocity,
    input  ack
  );

  modport consumer (
    input  req, note, velocity,
    output ack
  );

endinterface

`default_nettype wire

//--- midi_note_parser.sv
`timescale 1ns/1ps
`default_nettype none

module midi_note_parser
  import drum_meter_pkg::*;
#(
  parameter logic [3:0] MIDI_CHANNEL = 4'd9
) (
  input wire logic       clk_midi,
  input wire logic       rst,
  input wire logic       byte_valid,
  input wire midi_byte_t midi_byte,
  note_event_if.producer evt
);

  parser_state_t state;
  midi_data_t    key;

  logic is_status;
  logic is_note_on;
  logic note_done;
  logic accept;

  assign is_status  = midi_byte[7];
  assign is_note_on = (midi_byte[7:4] == 4'h9) && (midi_byte[3:0] == MIDI_CHANNEL);

  // velocity byte closes a note-on
  assign note_done = byte_valid && !is_status && (state == WAIT_VELOCITY);

  // handshake still busy drops the event
  assign accept = note_done && !evt.req && !evt.ack;

  always_ff @(posedge clk_midi) begin
    if (rst) begin
      state <= IDLE;
    end else if (byte_valid) begin
      if (is_status) begin
        state <= is_note_on ? WAIT_KEY : IDLE;  // anything else ends running status
      end else begin
        case (state)
          WAIT_KEY:      state <= WAIT_VELOCITY;
          WAIT_VELOCITY: state <= WAIT_KEY;  // running status
          default:       state <= IDLE;      // stray data
        endcase
      end
    end
  end

  always_ff @(posedge clk_midi) begin
    if (byte_valid && !is_status && (state == WAIT_KEY)) begin
      key <= midi_byte[6:0];
    end
  end

  always_ff @(posedge clk_midi) begin
    if (accept) begin
      evt.note     <= key;
      evt.velocity <= midi_byte[6:0];
    end
  end

  always_ff @(posedge clk_midi) begin
    if (rst) begin
      evt.req <= 1'b0;
    end else if (evt.ack) begin
      evt.req <= 1'b0;
    end else if (accept) begin
      evt.req <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- note_event_cdc.sv
`timescale 1ns/1ps
`default_nettype none

module note_event_cdc
  import drum_meter_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input wire logic clk_midi,
  input wire logic clk_pixel,
  input wire logic rst,
  note_event_if.consumer in,
  note_event_if.producer out
);

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,
    OUT_RELEASE
  } out_state_t;

  // clk_midi side
  midi_data_t             note_hold;
  midi_data_t             velocity_hold;
  logic                   req_q;
  logic                   evt_toggle;  // flips once per event
  logic [SYNC_STAGES-1:0] done_sync;
  logic                   busy;
  logic                   start;

  // clk_pixel side
  logic [SYNC_STAGES-1:0] evt_sync;
  logic                   done_toggle;
  out_state_t             out_state;
  logic                   new_evt;

  assign busy  = evt_toggle != done_sync[SYNC_STAGES-1];
  assign start = in.req && !req_q;

  always_ff @(posedge clk_midi) begin
    if (start) begin
      note_hold     <= in.note;
      velocity_hold <= in.velocity;
    end
  end

  always_ff @(posedge clk_midi) begin
    if (rst) begin
      req_q      <= 1'b0;
      evt_toggle <= 1'b0;
      done_sync  <= '0;
      in.ack     <= 1'b0;
    end else begin
      req_q     <= in.req;
      done_sync <= {done_sync[SYNC_STAGES-2:0], done_toggle};
      if (start) begin
        evt_toggle <= !evt_toggle;
      end
      if (!in.req) begin
        in.ack <= 1'b0;
      end else if (req_q && !busy) begin
        in.ack <= 1'b1;  // pixel side finished
      end
    end
  end

  assign new_evt = evt_sync[SYNC_STAGES-1] != done_toggle;

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      evt_sync    <= '0;
      done_toggle <= 1'b0;
      out_state   <= OUT_IDLE;
    end else begin
      evt_sync <= {evt_sync[SYNC_STAGES-2:0], evt_toggle};
      case (out_state)
        OUT_IDLE:    if (new_evt) out_state <= OUT_REQ;
        OUT_REQ:     if (out.ack) out_state <= OUT_RELEASE;
        OUT_RELEASE: begin
          if (!out.ack) begin
            done_toggle <= !done_toggle;  // report back to clk_midi
            out_state   <= OUT_IDLE;
          end
        end
        default:     out_state <= OUT_IDLE;
      endcase
    end
  end

  // held data is quiet while the pixel handshake runs
  assign out.req      = out_state == OUT_REQ;
  assign out.note     = note_hold;
  assign out.velocity = velocity_hold;

endmodule

`default_nettype wire

//--- note_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module note_tracker
  import drum_meter_pkg::*;
(
  input wire logic       clk_pixel,
  input wire logic       rst,
  input wire logic       new_frame,
  note_event_if.consumer evt,
  output intensity_t     intensity [INSTRUMENT_COUNT]
);

  logic take;

  // frame decay wins, event waits a cycle
  assign take = evt.req && !evt.ack && !new_frame;

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
        intensity[i] <= '0;
      end
    end else if (new_frame) begin
      for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
        if (intensity[i] > INSTRUMENT_DECAY[i]) begin
          intensity[i] <= intensity[i] - INSTRUMENT_DECAY[i];
        end else begin
          intensity[i] <= '0;
        end
      end
    end else if (take) begin
      for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
        if (evt.note == INSTRUMENT_KEYS[i]) begin
          intensity[i] <= evt.velocity;
        end
      end
    end
  end

  // unmapped keys are still acked
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      evt.ack <= 1'b0;
    end else if (take) begin
      evt.ack <= 1'b1;
    end else if (!evt.req) begin
      evt.ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
  parameter int FRAME_CYCLES = 420000
) (
  input wire logic clk_pixel,
  input wire logic rst,
  output logic     new_frame
);

  localparam int COUNT_W = $clog2(FRAME_CYCLES);

  logic [COUNT_W-1:0] count;
  logic               last_cycle;

  assign last_cycle = count == COUNT_W'(FRAME_CYCLES - 1);

  // stand-in for vblank start
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      count     <= '0;
      new_frame <= 1'b0;
    end else begin
      count     <= last_cycle ? '0 : count + COUNT_W'(1);
      new_frame <= last_cycle;
    end
  end

endmodule

`default_nettype wire

//--- drum_meter_top.sv
`timescale 1ns/1ps
`default_nettype none

module drum_meter_top
  import drum_meter_pkg::*;
#(
  parameter logic [3:0] MIDI_CHANNEL = 4'd9,  // drum channel
  parameter int         SYNC_STAGES  = 2,
  parameter int         FRAME_CYCLES = 420000
) (
  input wire logic       clk_midi,
  input wire logic       clk_pixel,
  input wire logic       rst,
  input wire logic       midi_byte_valid,
  input wire midi_byte_t midi_byte,
  output logic           frame_start,
  output logic [INSTRUMENT_COUNT*$bits(intensity_t)-1:0] intensities
);

  localparam int IW = $bits(intensity_t);

  note_event_if midi_evt ();   // clk_midi
  note_event_if pixel_evt ();  // clk_pixel

  logic       new_frame;
  intensity_t intensity [INSTRUMENT_COUNT];

  midi_note_parser #(
    .MIDI_CHANNEL(MIDI_CHANNEL)
  ) u_parser (
    .clk_midi  (clk_midi),
    .rst       (rst),
    .byte_valid(midi_byte_valid),
    .midi_byte (midi_byte),
    .evt       (midi_evt.producer)
  );

  note_event_cdc #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_cdc (
    .clk_midi (clk_midi),
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .in       (midi_evt.consumer),
    .out      (pixel_evt.producer)
  );

  note_tracker u_tracker (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .new_frame(new_frame),
    .evt      (pixel_evt.consumer),
    .intensity(intensity)
  );

  frame_timer #(
    .FRAME_CYCLES(FRAME_CYCLES)
  ) u_frame_timer (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .new_frame(new_frame)
  );

  assign frame_start = new_frame;

  // instrument 0 in the low bits
  for (genvar i = 0; i < INSTRUMENT_COUNT; i++) begin : g_flat
    assign intensities[i*IW +: IW] = intensity[i];
  end

endmodule

`default_nettype wire

//--- tb_drum_meter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_drum_meter;

  localparam int MIDI_PERIOD    = 14;
  localparam int FRAME_CYCLES   = 200;
  localparam int TIMEOUT_CYCLES = 6000;  // 6 tests x 4 frames x 200 plus margin

  // bass drum, snare, open hi-hat
  localparam logic [6:0] KEYS  [3] = '{7'd36, 7'd38, 7'd46};
  localparam logic [6:0] DECAY [3] = '{7'd127, 7'd16, 7'd3};

  logic        clk_midi  = 1'b0;
  logic        clk_pixel = 1'b0;
  logic        rst;
  logic        midi_byte_valid;
  logic [7:0]  midi_byte;
  logic        frame_start;
  logic [20:0] intensities;

  logic [6:0]  expected [3];
  logic [31:0] lfsr = 32'ha7c897eb;
  string       test_name = "reset state";
  logic        check_due = 1'b0;
  int          check_errors = 0;
  int          errors_before = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  drum_meter_top #(
    .MIDI_CHANNEL(4'd9),
    .SYNC_STAGES (2),
    .FRAME_CYCLES(FRAME_CYCLES)
  ) DUT (
    .clk_midi       (clk_midi),
    .clk_pixel      (clk_pixel),
    .rst            (rst),
    .midi_byte_valid(midi_byte_valid),
    .midi_byte      (midi_byte),
    .frame_start    (frame_start),
    .intensities    (intensities)
  );

  always #5 clk_pixel = ~clk_pixel;
  always #(MIDI_PERIOD / 2) clk_midi = ~clk_midi;

  always @(posedge clk_pixel) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d clk_pixel cycles", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [6:0] intensity_of(input int i);
    return intensities[i*7 +: 7];
  endfunction

  task automatic random_velocity(output logic [6:0] v);
    v = '0;
    for (int b = 0; b < 7; b++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[5:0], lfsr[0]};
    end
    if (v == 7'd0) v = 7'd1;  // keep strikes visible
  endtask

  task automatic check_equal(input string what, input int exp_v, input int act_v);
    assert (act_v == exp_v) else begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp_v, act_v);
      check_errors++;
    end
  endtask

  // model of a note-on that reaches the tracker
  task automatic strike(input logic [6:0] key, input logic [6:0] vel);
    for (int i = 0; i < 3; i++) begin
      if (KEYS[i] == key) expected[i] = vel;
    end
  endtask

  // compare at frame_start and again once the decay has landed
  always @(negedge clk_pixel) begin
    if (check_due) begin
      for (int i = 0; i < 3; i++) begin
        check_equal($sformatf("intensity %0d", i), int'(expected[i]), int'(intensity_of(i)));
      end
    end
    check_due = frame_start === 1'b1;
    if (check_due) begin
      for (int i = 0; i < 3; i++) begin
        check_equal($sformatf("intensity %0d before decay", i), int'(expected[i]),
                    int'(intensity_of(i)));
        expected[i] = (expected[i] > DECAY[i]) ? expected[i] - DECAY[i] : 7'd0;
      end
    end
  end

  task automatic send_byte(input logic [7:0] b);
    @(posedge clk_midi);
    #1;
    midi_byte       = b;
    midi_byte_valid = 1'b1;
    @(posedge clk_midi);
    #1;
    midi_byte_valid = 1'b0;
    repeat (8) @(posedge clk_midi);  // parser idle before the next byte
  endtask

  task automatic send_pair(input logic [6:0] key, input logic [6:0] vel);
    send_byte({1'b0, key});
    send_byte({1'b0, vel});
  endtask

  task automatic wait_frame();
    @(negedge clk_pixel);
    while (frame_start !== 1'b1) @(negedge clk_pixel);
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    errors_before = check_errors;
    wait_frame();
  endtask

  task automatic end_test(input int frames);
    repeat (frames) wait_frame();
    repeat (2) @(negedge clk_pixel);  // last frame check
    if (check_errors == errors_before) tests_passed++;
    else tests_failed++;
    $display("test %s: %s", test_name, (check_errors == errors_before) ? "passed" : "failed");
  endtask

  initial begin
    int         low_cycles;
    logic [6:0] v1, v2, v3;
    rst             = 1'b1;
    midi_byte_valid = 1'b0;
    midi_byte       = 8'h00;
    for (int i = 0; i < 3; i++) expected[i] = 7'd0;
    repeat (16) @(posedge clk_pixel);
    #1;
    rst = 1'b0;

    for (int i = 0; i < 3; i++) begin
      check_equal("intensity after reset", 0, int'(intensity_of(i)));
    end
    low_cycles = 0;
    do begin
      @(posedge clk_pixel);
      low_cycles++;
      @(negedge clk_pixel);
    end while (frame_start !== 1'b1);
    check_equal("cycles to first frame_start", FRAME_CYCLES, low_cycles);
    end_test(0);

    begin_test("basic note-on");
    random_velocity(v1);
    send_byte(8'h99);
    send_pair(7'd38, v1);
    strike(7'd38, v1);
    end_test(3);

    begin_test("running status");
    random_velocity(v1);
    random_velocity(v2);
    random_velocity(v3);
    send_byte(8'h99);
    send_pair(7'd36, v1);
    send_pair(7'd46, v2);
    send_pair(7'd38, v3);
    strike(7'd36, v1);
    strike(7'd46, v2);
    strike(7'd38, v3);
    end_test(3);

    begin_test("filtering");
    send_byte(8'h90);  // channel 0
    send_pair(7'd36, 7'd100);
    send_byte(8'h89);  // note-off, clears running status
    send_pair(7'd38, 7'd100);
    send_pair(7'd38, 7'd90);  // no status in force
    send_byte(8'h99);
    send_pair(7'd40, 7'd100);  // unmapped key
    end_test(3);

    begin_test("velocity zero and re-strike");
    random_velocity(v1);
    random_velocity(v2);
    random_velocity(v3);
    send_byte(8'h99);
    send_pair(7'd46, v1);
    send_pair(7'd38, v2);
    strike(7'd46, v1);
    strike(7'd38, v2);
    wait_frame();
    send_byte(8'h99);
    send_pair(7'd46, 7'd0);
    send_pair(7'd38, v3);
    strike(7'd46, 7'd0);
    strike(7'd38, v3);
    end_test(3);

    begin_test("status change mid-stream");
    random_velocity(v1);
    random_velocity(v2);
    random_velocity(v3);
    send_byte(8'h99);
    send_pair(7'd36, v1);
    send_pair(7'd38, v2);
    send_byte(8'h89);
    send_pair(7'd46, v3);  // dropped, note-off status in force
    strike(7'd36, v1);
    strike(7'd38, v2);
    end_test(3);

    $display("%0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
drum_meter_pkg.sv
note_event_if.sv
midi_note_parser.sv
note_event_cdc.sv
note_tracker.sv
frame_timer.sv
drum_meter_top.sv
tb_drum_meter.sv

//--- run_sim.sh
#!/bin/sh
# build and run the drum meter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_drum_meter \
  -o tb_drum_meter && ./obj_dir/tb_drum_meter > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
